/* load_streamer_stim.txt */
// Words 0 to 255 are the memory image, word a holds bytes a+3 a+2 a+1 a from high to low
// Then job records: base, length, cast flag, expected beat count, expected beats
03020100 04030201 05040302 06050403 07060504 08070605 09080706 0a090807
0b0a0908 0c0b0a09 0d0c0b0a 0e0d0c0b 0f0e0d0c 100f0e0d 11100f0e 1211100f
13121110 14131211 15141312 16151413 17161514 18171615 19181716 1a191817
1b1a1918 1c1b1a19 1d1c1b1a 1e1d1c1b 1f1e1d1c 201f1e1d 21201f1e 2221201f
23222120 24232221 25242322 26252423 27262524 28272625 29282726 2a292827
2b2a2928 2c2b2a29 2d2c2b2a 2e2d2c2b 2f2e2d2c 302f2e2d 31302f2e 3231302f
33323130 34333231 35343332 36353433 37363534 38373635 39383736 3a393837
3b3a3938 3c3b3a39 3d3c3b3a 3e3d3c3b 3f3e3d3c 403f3e3d 41403f3e 4241403f
43424140 44434241 45444342 46454443 47464544 48474645 49484746 4a494847
4b4a4948 4c4b4a49 4d4c4b4a 4e4d4c4b 4f4e4d4c 504f4e4d 51504f4e 5251504f
53525150 54535251 55545352 56555453 57565554 58575655 59585756 5a595857
5b5a5958 5c5b5a59 5d5c5b5a 5e5d5c5b 5f5e5d5c 605f5e5d 61605f5e 6261605f
63626160 64636261 65646362 66656463 67666564 68676665 69686766 6a696867
6b6a6968 6c6b6a69 6d6c6b6a 6e6d6c6b 6f6e6d6c 706f6e6d 71706f6e 7271706f
73727170 74737271 75747372 76757473 77767574 78777675 79787776 7a797877
7b7a7978 7c7b7a79 7d7c7b7a 7e7d7c7b 7f7e7d7c 807f7e7d 81807f7e 8281807f
83828180 84838281 85848382 86858483 87868584 88878685 89888786 8a898887
8b8a8988 8c8b8a89 8d8c8b8a 8e8d8c8b 8f8e8d8c 908f8e8d 91908f8e 9291908f
93929190 94939291 95949392 96959493 97969594 98979695 99989796 9a999897
9b9a9998 9c9b9a99 9d9c9b9a 9e9d9c9b 9f9e9d9c a09f9e9d a1a09f9e a2a1a09f
a3a2a1a0 a4a3a2a1 a5a4a3a2 a6a5a4a3 a7a6a5a4 a8a7a6a5 a9a8a7a6 aaa9a8a7
abaaa9a8 acabaaa9 adacabaa aeadacab afaeadac b0afaead b1b0afae b2b1b0af
b3b2b1b0 b4b3b2b1 b5b4b3b2 b6b5b4b3 b7b6b5b4 b8b7b6b5 b9b8b7b6 bab9b8b7
bbbab9b8 bcbbbab9 bdbcbbba bebdbcbb bfbebdbc c0bfbebd c1c0bfbe c2c1c0bf
c3c2c1c0 c4c3c2c1 c5c4c3c2 c6c5c4c3 c7c6c5c4 c8c7c6c5 c9c8c7c6 cac9c8c7
cbcac9c8 cccbcac9 cdcccbca cecdcccb cfcecdcc d0cfcecd d1d0cfce d2d1d0cf
d3d2d1d0 d4d3d2d1 d5d4d3d2 d6d5d4d3 d7d6d5d4 d8d7d6d5 d9d8d7d6 dad9d8d7
dbdad9d8 dcdbdad9 dddcdbda dedddcdb dfdedddc e0dfdedd e1e0dfde e2e1e0df
e3e2e1e0 e4e3e2e1 e5e4e3e2 e6e5e4e3 e7e6e5e4 e8e7e6e5 e9e8e7e6 eae9e8e7
ebeae9e8 ecebeae9 edecebea eeedeceb efeeedec f0efeeed f1f0efee f2f1f0ef
f3f2f1f0 f4f3f2f1 f5f4f3f2 f6f5f4f3 f7f6f5f4 f8f7f6f5 f9f8f7f6 faf9f8f7
fbfaf9f8 fcfbfaf9 fdfcfbfa fefdfcfb fffefdfc 00fffefd 0100fffe 020100ff
// Pass mode, output always ready
0010 03 0 3
13121110 14131211 15141312
// Cast mode, output always ready
0020 02 1 4
21002000 23002200 22002100 24002300
// Cast mode under random stalls
0050 03 1 6
51005000 53005200 52005100 54005300 53005200 55005400
// Pass mode under random stalls, with a start pulse mid job
0060 08 0 8
63626160 64636261 65646362 66656463 67666564 68676665 69686766 6a696867
// Length 0 ends the job list
0000 00

/* load_streamer.f */
+incdir+.
streamer_pkg.sv
streamer_if.sv
load_requester.sv
load_fifo.sv
load_castin.sv
load_streamer.sv
load_streamer_props.sv
load_streamer_tb.sv

/* Bender.yml */
package:
  name: load_streamer

sources:
  - include_dirs:
      - .
    files:
      - streamer_pkg.sv
      - streamer_if.sv
      - load_requester.sv
      - load_fifo.sv
      - load_castin.sv
      - load_streamer.sv
  - target: test
    include_dirs:
      - .
    files:
      - load_streamer_props.sv
      - load_streamer_tb.sv

/* load_streamer_tb.sv */
// Load streamer testbench with a memory model, jobs read from the stim file and beat checks
`include "streamer_cfg.svh"

module load_streamer_tb;
  timeunit 1ns;
  timeprecision 100ps;

  // Memory image first, job records after it
  localparam int STIM_WORDS = 512;
  localparam int MEM_WORDS  = 256;
  // Jobs from this index on get random grants, response delays and stalls
  localparam int RAND_FROM  = 2;

  logic               clk_i         = 1'b0;
  logic               rst_n_i       = 1'b0;
  logic               start_i       = 1'b0;
  logic [`ADDR_W-1:0] base_addr_i   = '0;
  logic [`LEN_W-1:0]  length_i      = '0;
  logic               cast_i        = 1'b0;
  logic               mem_req_o;
  logic [`ADDR_W-1:0] mem_addr_o;
  logic               mem_gnt_i     = 1'b0;
  logic               mem_r_valid_i = 1'b0;
  logic [`WORD_W-1:0] mem_r_data_i  = '0;
  logic               out_valid_o;
  logic [`WORD_W-1:0] out_data_o;
  logic               out_last_o;
  logic               out_ready_i   = 1'b0;
  logic               done_o;

  logic [`WORD_W-1:0] stim [STIM_WORDS];
  logic [31:0]        lfsr_q    = 32'h2d59;
  int                 cyc       = 0;
  int                 limit     = 0;
  // Current job as the monitor sees it
  logic [`ADDR_W-1:0] job_base  = '0;
  logic               job_cast  = 1'b0;
  logic               job_rand  = 1'b0;
  int                 job_ptr   = 0;
  int                 exp_cnt   = 0;
  int                 beat_cnt  = 0;
  int                 grant_cnt = 0;
  int                 done_cnt  = 0;
  int                 errors    = 0;
  // Read responses still owed by the memory model
  logic [`WORD_W-1:0] rsp_data_q [$];
  int                 rsp_due_q [$];

  always #10 clk_i = ~clk_i;

  load_streamer UUT (
    .clk_i         ( clk_i         ),
    .rst_n_i       ( rst_n_i       ),
    .start_i       ( start_i       ),
    .base_addr_i   ( base_addr_i   ),
    .length_i      ( length_i      ),
    .cast_i        ( cast_i        ),
    .mem_req_o     ( mem_req_o     ),
    .mem_addr_o    ( mem_addr_o    ),
    .mem_gnt_i     ( mem_gnt_i     ),
    .mem_r_valid_i ( mem_r_valid_i ),
    .mem_r_data_i  ( mem_r_data_i  ),
    .out_valid_o   ( out_valid_o   ),
    .out_data_o    ( out_data_o    ),
    .out_last_o    ( out_last_o    ),
    .out_ready_i   ( out_ready_i   ),
    .done_o        ( done_o        )
  );

  bind load_streamer load_streamer_props i_props (.*);

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  task automatic draw_bits(input int n, output logic [3:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v      = {v[2:0], lfsr_q[0]};
    end
  endtask

  always @(posedge clk_i) begin
    cyc <= cyc + 1;
    if (cyc >= limit) begin
      $display("Timeout: the run did not finish within %0d cycles", limit);
      $display("tests failed");
      $finish;
    end
  end

  // Memory model, ready driver and beat monitor, all on the rising edge
  always @(posedge clk_i) begin
    logic [3:0]         r;
    logic [`ADDR_W-1:0] exp_addr;
    int                 words_out;
    // Grant seen on this edge, queue the read response
    if (mem_req_o && mem_gnt_i) begin
      exp_addr = job_base + grant_cnt[`ADDR_W-1:0];
      assert (mem_addr_o == exp_addr) else begin
        $display("FAILED mem_addr_o expected %h got %h", exp_addr, mem_addr_o);
        errors++;
      end
      if (job_rand) begin
        draw_bits(2, r);
      end else begin
        r = '0;
      end
      rsp_data_q.push_back(stim[mem_addr_o[7:0]]);
      rsp_due_q.push_back(cyc + int'(r));
      grant_cnt++;
    end
    // Responses leave in request order, one per cycle at most
    mem_r_valid_i <= 1'b0;
    if (rsp_due_q.size() > 0 && rsp_due_q[0] <= cyc) begin
      mem_r_valid_i <= 1'b1;
      mem_r_data_i  <= rsp_data_q.pop_front();
      void'(rsp_due_q.pop_front());
    end
    if (job_rand) begin
      draw_bits(1, r);
      mem_gnt_i <= r[0];
    end else begin
      mem_gnt_i <= 1'b1;
    end
    // Output beat against the expected words of the job
    if (out_valid_o && out_ready_i) begin
      assert (beat_cnt < exp_cnt) else begin
        $display("Output beat arrived after the last expected one");
        errors++;
      end
      if (beat_cnt < exp_cnt) begin
        assert (out_data_o == stim[job_ptr + beat_cnt]) else begin
          $display("FAILED out_data_o expected %h got %h", stim[job_ptr + beat_cnt],
                   out_data_o);
          errors++;
        end
        assert (out_last_o == (beat_cnt == exp_cnt - 1)) else begin
          $display("FAILED out_last_o expected %h got %h", beat_cnt == exp_cnt - 1,
                   out_last_o);
          errors++;
        end
      end
      beat_cnt++;
    end
    // Words granted but not yet out, one may sit in the cast stage
    words_out = job_cast ? beat_cnt / 2 : beat_cnt;
    assert (grant_cnt - words_out <= `FIFO_DEPTH + 1) else begin
      $display("Credit bound exceeded with %0d words in flight", grant_cnt - words_out);
      errors++;
    end
    if (done_o) begin
      done_cnt++;
    end
    if (job_rand) begin
      draw_bits(1, r);
      out_ready_i <= r[0];
    end else begin
      out_ready_i <= 1'b1;
    end
  end

  initial begin
    int   ptr;
    int   next_ptr;
    int   total;
    int   job;
    int   bad_before;
    int   tests_ok;
    int   tests_bad;
    logic rogue;
    $readmemh("load_streamer_stim.txt", stim);
    // Timeout grows with the expected beats of all jobs
    ptr   = MEM_WORDS;
    total = 0;
    while (stim[ptr + 1] != '0) begin
      total += stim[ptr + 3];
      ptr   += 4 + stim[ptr + 3];
    end
    limit = 40 * total + 200;
    repeat (4) @(posedge clk_i);
    rst_n_i <= 1'b1;
    ptr       = MEM_WORDS;
    job       = 0;
    tests_ok  = 0;
    tests_bad = 0;
    while (stim[ptr + 1] != '0) begin
      @(negedge clk_i);
      job_base   = stim[ptr][`ADDR_W-1:0];
      job_cast   = stim[ptr + 2][0];
      exp_cnt    = stim[ptr + 3];
      job_ptr    = ptr + 4;
      job_rand   = (job >= RAND_FROM);
      beat_cnt   = 0;
      grant_cnt  = 0;
      done_cnt   = 0;
      next_ptr   = ptr + 4 + exp_cnt;
      // Last job also gets a start pulse while it runs
      rogue      = (stim[next_ptr + 1] == '0);
      bad_before = errors + UUT.i_props.fail_cnt;
      @(posedge clk_i);
      start_i     <= 1'b1;
      base_addr_i <= job_base;
      length_i    <= stim[ptr + 1][`LEN_W-1:0];
      cast_i      <= job_cast;
      @(posedge clk_i);
      start_i <= 1'b0;
      if (rogue) begin
        do @(negedge clk_i); while (beat_cnt == 0);
        @(posedge clk_i);
        start_i     <= 1'b1;
        base_addr_i <= job_base + 'h80;
        length_i    <= 8'd1;
        @(posedge clk_i);
        start_i <= 1'b0;
      end
      do @(negedge clk_i); while (done_cnt == 0);
      // Room for a stray second job to show itself
      repeat (4) @(negedge clk_i);
      assert (beat_cnt == exp_cnt) else begin
        $display("Job %0d gave %0d beats instead of %0d", job, beat_cnt, exp_cnt);
        errors++;
      end
      assert (grant_cnt == stim[ptr + 1]) else begin
        $display("Job %0d issued %0d reads instead of %0d", job, grant_cnt, stim[ptr + 1]);
        errors++;
      end
      assert (done_cnt == 1) else begin
        $display("Job %0d saw done_o pulse %0d times instead of once", job, done_cnt);
        errors++;
      end
      if (errors + UUT.i_props.fail_cnt == bad_before) begin
        tests_ok++;
        $display("Test %0d %s base %h: ok, %0d beats", job, job_cast ? "cast" : "pass",
                 job_base, beat_cnt);
      end else begin
        tests_bad++;
        $display("Test %0d %s base %h: FAILED", job, job_cast ? "cast" : "pass", job_base);
      end
      ptr = next_ptr;
      job++;
    end
    $display("Summary: %0d jobs clean, %0d jobs with errors", tests_ok, tests_bad);
    if (tests_bad == 0 && errors == 0 && UUT.i_props.fail_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* load_streamer_props.sv */
// Load streamer protocol checks for the memory handshake, output stream and reset state
`include "streamer_cfg.svh"

module load_streamer_props (
  input logic               clk_i,
  input logic               rst_n_i,
  input logic               mem_req_o,
  input logic [`ADDR_W-1:0] mem_addr_o,
  input logic               mem_gnt_i,
  input logic               out_valid_o,
  input logic [`WORD_W-1:0] out_data_o,
  input logic               out_last_o,
  input logic               out_ready_i,
  input logic               done_o
);
  timeunit 1ns;
  timeprecision 100ps;

  // Failed assertions, read by the testbench top
  int fail_cnt = 0;

  // Request and address hold until granted
  req_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_req_o && !mem_gnt_i |=> mem_req_o && $stable(mem_addr_o))
    else begin
      $error("mem_req_o dropped or mem_addr_o moved before mem_gnt_i");
      fail_cnt++;
    end

  // Output beat holds while stalled
  out_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o) && $stable(out_last_o))
    else begin
      $error("out_valid_o dropped or out_data_o moved while out_ready_i was low");
      fail_cnt++;
    end

  // Control outputs come out of reset low
  rst_low: assert property (@(posedge clk_i)
    !rst_n_i |=> !mem_req_o && !out_valid_o && !out_last_o && !done_o)
    else begin
      $error("Control outputs not low after reset");
      fail_cnt++;
    end

endmodule

/* load_streamer.sv */
// Load streamer top: memory read requester, load FIFO and input cast
`include "streamer_cfg.svh"

module load_streamer (
  input  logic                clk_i,
  input  logic                rst_n_i,
  // Job descriptor
  input  logic                start_i,
  input  logic [`ADDR_W-1:0]  base_addr_i,
  input  logic [`LEN_W-1:0]   length_i,
  input  logic                cast_i,
  // Memory read port
  output logic                mem_req_o,
  output logic [`ADDR_W-1:0]  mem_addr_o,
  input  logic                mem_gnt_i,
  input  logic                mem_r_valid_i,
  input  logic [`WORD_W-1:0]  mem_r_data_i,
  // Output stream
  output logic                out_valid_o,
  output logic [`WORD_W-1:0]  out_data_o,
  output logic                out_last_o,
  input  logic                out_ready_i,
  output logic                done_o
);

  credit_word_if rd_chan ();
  stream_word_if ld_stream ();

  // Producer, issues reads against its credits
  load_requester i_requester (
    .clk_i         ( clk_i         ),
    .rst_n_i       ( rst_n_i       ),
    .start_i       ( start_i       ),
    .base_addr_i   ( base_addr_i   ),
    .length_i      ( length_i      ),
    .mem_req_o     ( mem_req_o     ),
    .mem_addr_o    ( mem_addr_o    ),
    .mem_gnt_i     ( mem_gnt_i     ),
    .mem_r_valid_i ( mem_r_valid_i ),
    .mem_r_data_i  ( mem_r_data_i  ),
    .chan_o        ( rd_chan       )
  );

  // Buffer between the memory and the cast
  load_fifo i_fifo (
    .clk_i   ( clk_i     ),
    .rst_n_i ( rst_n_i   ),
    .push_i  ( rd_chan   ),
    .pop_o   ( ld_stream )
  );

  // Consumer, drives the output stream
  load_castin i_castin (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .cast_i      ( cast_i      ),
    .in_i        ( ld_stream   ),
    .out_valid_o ( out_valid_o ),
    .out_data_o  ( out_data_o  ),
    .out_last_o  ( out_last_o  ),
    .out_ready_i ( out_ready_i ),
    .done_o      ( done_o      )
  );

endmodule

/* load_castin.sv */
// Input cast stage: passes words or expands FP8 words into two FP16 beats
`include "streamer_cfg.svh"

module load_castin
  import streamer_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                cast_i,
  stream_word_if.sink         in_i,
  output logic                out_valid_o,
  output logic [`WORD_W-1:0]  out_data_o,
  output logic                out_last_o,
  input  logic                out_ready_i,
  output logic                done_o
);

  logic      valid_q;
  mem_word_u word_q;
  logic      last_q;
  // Which half of the held word is on the output in cast mode
  logic      half_q;
  logic      done_q;
  logic      final_beat;
  logic      beat_done;
  logic      accept;
  mem_word_u cast_beat;

  // Pass mode has one beat per word, cast mode two
  assign final_beat = !cast_i || half_q;
  assign beat_done  = valid_q && out_ready_i && final_beat;
  // Take a new word when empty or when the held word leaves this cycle
  assign in_i.ready = !valid_q || (out_ready_i && final_beat);
  assign accept     = in_i.valid && in_i.ready;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
      half_q  <= 1'b0;
    end else if (accept) begin
      valid_q <= 1'b1;
      half_q  <= 1'b0;
    end else if (valid_q && out_ready_i) begin
      if (final_beat) begin
        valid_q <= 1'b0;
      end else begin
        half_q <= 1'b1;
      end
    end
  end

  // Held payload
  always_ff @(posedge clk_i) begin
    if (accept) begin
      word_q <= in_i.data;
      last_q <= in_i.last;
    end
  end

  // E5M2 shares the FP16 exponent, so the byte becomes the upper half
  // Bytes 0 and 1 go first, then bytes 2 and 3
  always_comb begin
    cast_beat.fp16[0] = {word_q.fp8[{half_q, 1'b0}], 8'h00};
    cast_beat.fp16[1] = {word_q.fp8[{half_q, 1'b1}], 8'h00};
  end

  assign out_valid_o = valid_q;
  assign out_data_o  = cast_i ? cast_beat.raw : word_q.raw;
  assign out_last_o  = valid_q && last_q && final_beat;

  // Job end flag, one cycle after the last beat leaves
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      done_q <= 1'b0;
    end else begin
      done_q <= beat_done && last_q;
    end
  end

  assign done_o = done_q;

endmodule

/* load_fifo.sv */
// Load FIFO buffering read words and returning one credit per pop
`include "streamer_cfg.svh"

module load_fifo
  import streamer_pkg::*;
(
  input  logic           clk_i,
  input  logic           rst_n_i,
  credit_word_if.fifo    push_i,
  stream_word_if.source  pop_o
);

  localparam int unsigned PTR_W = $clog2(`FIFO_DEPTH);
  localparam int unsigned CNT_W = $clog2(`FIFO_DEPTH + 1);

  // Word and last flag storage
  mem_word_u        data_mem [`FIFO_DEPTH];
  logic             last_mem [`FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             pop_fire;

  // Head entry is presented as soon as it is written
  assign pop_o.valid = (count_q != '0);
  assign pop_o.data  = data_mem[rd_ptr_q];
  assign pop_o.last  = last_mem[rd_ptr_q];
  assign pop_fire    = pop_o.valid && pop_o.ready;

  // Freed slot goes straight back to the requester
  assign push_i.credit = pop_fire;

  // The requester reserves the space before it reads, so a push finds a free slot
  always_ff @(posedge clk_i) begin
    if (push_i.valid) begin
      data_mem[wr_ptr_q] <= push_i.data;
      last_mem[wr_ptr_q] <= push_i.last;
    end
  end

  // Pointers wrap on their own since the depth is a power of two
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i.valid) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_fire) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push_i.valid, pop_fire})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

/* load_requester.sv */
// Load requester: job control, read address generation and credit accounting
`include "streamer_cfg.svh"

module load_requester
  import streamer_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                start_i,
  input  logic [`ADDR_W-1:0]  base_addr_i,
  input  logic [`LEN_W-1:0]   length_i,
  output logic                mem_req_o,
  output logic [`ADDR_W-1:0]  mem_addr_o,
  input  logic                mem_gnt_i,
  input  logic                mem_r_valid_i,
  input  mem_word_u           mem_r_data_i,
  credit_word_if.requester    chan_o
);

  // Enough bits to hold a full credit count
  localparam int unsigned CRED_W = $clog2(`FIFO_DEPTH + 1);

  logic               busy_q;
  logic [`ADDR_W-1:0] addr_q;
  logic [`LEN_W-1:0]  req_left_q;
  logic [`LEN_W-1:0]  rsp_left_q;
  logic [CRED_W-1:0]  credits_q;
  logic [CRED_W-1:0]  credits_d;
  logic               gnt_fire;
  logic               rsp_fire;
  logic               rsp_valid_q;
  mem_word_u          rsp_data_q;
  logic               rsp_last_q;

  // Request only with words left and a free FIFO slot reserved
  // Both terms only drop on a grant, so the request holds until granted
  assign mem_req_o  = busy_q && (req_left_q != '0) && (credits_q != '0);
  assign mem_addr_o = addr_q;
  assign gnt_fire   = mem_req_o && mem_gnt_i;
  // Stray responses outside a job are dropped
  assign rsp_fire   = busy_q && mem_r_valid_i;

  // Job state, start is ignored while busy
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q     <= 1'b0;
      req_left_q <= '0;
      rsp_left_q <= '0;
    end else if (!busy_q) begin
      if (start_i) begin
        busy_q     <= 1'b1;
        req_left_q <= length_i;
        rsp_left_q <= length_i;
      end
    end else begin
      if (gnt_fire) begin
        req_left_q <= req_left_q - 1'b1;
      end
      if (rsp_fire) begin
        rsp_left_q <= rsp_left_q - 1'b1;
        // Final response closes the job
        if (rsp_left_q == `LEN_W'(1)) begin
          busy_q <= 1'b0;
        end
      end
    end
  end

  // Address walks up one word per grant
  always_ff @(posedge clk_i) begin
    if (!busy_q && start_i) begin
      addr_q <= base_addr_i;
    end else if (gnt_fire) begin
      addr_q <= addr_q + 1'b1;
    end
  end

  // Spend on grant, refund on FIFO pop, both may happen together
  always_comb begin
    credits_d = credits_q;
    if (gnt_fire && !chan_o.credit) begin
      credits_d = credits_q - 1'b1;
    end else if (!gnt_fire && chan_o.credit) begin
      credits_d = credits_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      credits_q <= CRED_W'(`FIFO_DEPTH);
    end else begin
      credits_q <= credits_d;
    end
  end

  // Response register toward the FIFO
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= rsp_fire;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rsp_fire) begin
      rsp_data_q <= mem_r_data_i;
      rsp_last_q <= (rsp_left_q == `LEN_W'(1));
    end
  end

  assign chan_o.valid = rsp_valid_q;
  assign chan_o.data  = rsp_data_q;
  assign chan_o.last  = rsp_last_q;

endmodule

/* streamer_if.sv */
// Internal links of the load streamer: credit-based word push and valid/ready stream
`include "streamer_cfg.svh"

// Requester to FIFO link
// Words arrive without back-pressure, space is reserved by credits
interface credit_word_if
  import streamer_pkg::*;
();

  logic      valid;
  mem_word_u data;
  logic      last;
  // One pulse per freed FIFO entry
  logic      credit;

  modport requester (
    output valid,
    output data,
    output last,
    input  credit
  );

  modport fifo (
    input  valid,
    input  data,
    input  last,
    output credit
  );

endinterface

// FIFO to cast stage link, plain valid/ready handshake
interface stream_word_if
  import streamer_pkg::*;
();

  logic      valid;
  mem_word_u data;
  logic      last;
  logic      ready;

  modport source (
    output valid,
    output data,
    output last,
    input  ready
  );

  modport sink (
    input  valid,
    input  data,
    input  last,
    output ready
  );

endinterface

/* streamer_pkg.sv */
// Load streamer package with the FP element types and the memory word views
`include "streamer_cfg.svh"

package streamer_pkg;

  // Half precision element
  typedef logic [15:0] fp16_t;

  // FP8 element in E5M2 format
  // Same exponent layout as FP16, so the cast is a plain shift
  typedef logic [7:0] fp8_t;

  // One memory word, seen as raw bits, two FP16 or four FP8 elements
  // Element 0 sits in the low bits in both element views
  typedef union packed {
    logic [`WORD_W-1:0]        raw;
    fp16_t [`WORD_W/16-1:0]    fp16;
    fp8_t  [`WORD_W/8-1:0]     fp8;
  } mem_word_u;

endpackage

/* streamer_cfg.svh */
// Load streamer configuration macros for word, address, length and FIFO sizing
`ifndef STREAMER_CFG_SVH
`define STREAMER_CFG_SVH

// Memory and stream word width in bits
`define WORD_W 32

// Word address width
`define ADDR_W 16

// Job length width, one job moves 1 to 255 words
`define LEN_W 8

// Load FIFO entries
// Also the number of read credits, must be a power of two
`define FIFO_DEPTH 4

`endif
